//--- win_filter_tests.txt
// Per image: 64 pixels in raster order, then 36 results as {median, pos}
// Results follow the raster order of each window's top-left pixel
// Image 0, distinct values
35 32 37 34 30 31 36 33 15 12 17 14 10 11 16 13
75 72 77 74 70 71 76 73 55 52 57 54 50 51 56 53
05 02 07 04 00 01 06 03 65 62 67 64 60 61 66 63
45 42 47 44 40 41 46 43 25 22 27 24 20 21 26 23
350 342 341 312 311 332 556 548 547 518 517 538
553 545 544 515 514 535 550 542 541 512 511 532
456 448 447 418 417 438 453 445 444 415 414 435
// Image 1, flat
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
804 804 804 804 804 804 804 804 804 804 804 804
804 804 804 804 804 804 804 804 804 804 804 804
804 804 804 804 804 804 804 804 804 804 804 804
// Image 2, repeated values
62 62 62 65 65 61 61 61 22 22 22 25 25 21 21 21
42 42 42 45 45 41 41 41 02 02 02 05 05 01 01 01
32 32 32 35 35 31 31 31 72 72 72 75 75 71 71 71
52 52 52 55 55 51 51 51 12 12 12 15 15 11 11 11
427 427 457 456 418 417 221 221 251 250 212 211
327 327 357 356 318 317 324 324 354 353 315 314
527 527 557 556 518 517 524 524 554 553 515 514

//--- win_filter.f
+incdir+.
win_filter_pkg.sv
position_encoder.sv
window_buffer.sv
pos_counter.sv
fill_fsm.sv
rank_select.sv
win_filter_top.sv
tb_clock.sv
win_filter_asserts.sv
win_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the median filter testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module win_filter_tb \
	-f win_filter.f -o win_filter_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/win_filter_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

//--- win_filter_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module win_filter_tb;
	import win_filter_pkg::*;

	localparam int IMG_PIX = `IMG_W * `IMG_W;
	localparam int OUT_N = (`IMG_W - `WIN_W + 1) * (`IMG_W - `WIN_W + 1);
	localparam int BLOCK = IMG_PIX + OUT_N;
	localparam int IMAGES = 3;
	localparam int TIMEOUT = 50;

	logic clk;
	logic rst;
	logic frame_start;
	logic pix_valid;
	pixel_t pix_data;
	logic out_valid;
	filt_out_t out_data;

	logic [11:0] tests_mem [IMAGES*BLOCK]; // Pixels then {median, pos} per image
	filt_out_t expect_q [$];

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	win_filter_top dut (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.pix_valid(pix_valid),
		.pix_data(pix_data),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	// One clock, results checked at the falling edge where they are stable
	task automatic tick;
		filt_out_t want;
		@(negedge clk);
		if (out_valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				report_error("A result strobe appeared with no complete window pending");
			end else begin
				want = expect_q.pop_front();
				assert (out_data == want) else report_error($sformatf(
					"CHECK FAILED out_data got median %h pos %h, expected median %h pos %h",
					out_data.median, out_data.pos, want.median, want.pos));
			end
		end
	endtask

	task automatic send_pixel(input pixel_t value);
		int gap;
		gap = $urandom % 3;
		repeat (gap) tick();
		pix_valid = 1'b1;
		pix_data = value;
		tick();
		pix_valid = 1'b0;
	endtask

	task automatic send_pixels(input int img, input int count);
		for (int k = 0; k < count; k++) begin
			send_pixel(tests_mem[img*BLOCK+k][7:0]);
		end
	endtask

	task automatic pulse_frame_start;
		frame_start = 1'b1;
		tick();
		frame_start = 1'b0;
	endtask

	task automatic run_image(input int img);
		int n;
		for (int k = 0; k < OUT_N; k++) begin
			expect_q.push_back(filt_out_t'(tests_mem[img*BLOCK+IMG_PIX+k]));
		end
		pulse_frame_start();
		send_pixels(img, IMG_PIX);
		n = 0;
		while (expect_q.size() != 0) begin
			tick();
			n++;
			if (expect_q.size() != 0 && n >= TIMEOUT) begin
				report_error($sformatf("Timed out waiting for the results of image %0d", img));
			end
		end
		repeat (4) tick(); // Any extra strobe shows up here
	endtask

	initial begin
		int n;
		frame_start = 1'b0;
		pix_valid = 1'b0;
		pix_data = '0;
		void'($urandom(50));
		$readmemh("win_filter_tests.txt", tests_mem);
		n = 0;
		while (rst !== 1'b0) begin
			tick();
			n++;
			if (rst !== 1'b0 && n >= TIMEOUT) begin
				report_error("Reset was never released");
			end
		end
		send_pixels(0, 3 * `IMG_W); // No frame started, so no output may follow
		repeat (4) tick();
		run_image(0);
		run_image(1);
		pulse_frame_start();
		send_pixels(0, 2 * `IMG_W + 2); // Aborted just before the first full window
		run_image(2);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- win_filter_asserts.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module win_filter_asserts (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic pix_valid,
	input logic [`COL_W-1:0] col,
	input logic [`COL_W-1:0] row,
	input win_filter_pkg::fill_state_t fill_state,
	input logic out_valid,
	input win_filter_pkg::filt_out_t out_data
);
	import win_filter_pkg::*;

	localparam int EDGE = `WIN_W - 1;
	localparam pos_t LAST_POS = pos_t'(`WIN_N - 1);

	logic completing; // Strobe that closes an interior window

	assign completing = pix_valid && !frame_start && (fill_state != IDLE)
		&& (row >= EDGE[`COL_W-1:0]) && (col >= EDGE[`COL_W-1:0]);

	a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	a_latency: assert property (@(posedge clk) disable iff (rst) completing |-> ##2 out_valid)
		else $error("No result two cycles after a completing pixel");

	a_pos_range: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (out_data.pos <= LAST_POS))
		else $error("Median position outside the window");

endmodule

bind win_filter_top win_filter_asserts u_asserts (
	.clk(clk),
	.rst(rst),
	.frame_start(frame_start),
	.pix_valid(pix_valid),
	.col(col),
	.row(row),
	.fill_state(fill_state),
	.out_valid(out_valid),
	.out_data(out_data)
);

`default_nettype wire

//--- tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// Five rising edges in reset, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- win_filter_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module win_filter_top (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic pix_valid,
	input win_filter_pkg::pixel_t pix_data,
	output logic out_valid,
	output win_filter_pkg::filt_out_t out_data
);
	import win_filter_pkg::*;

	win_u window;
	logic [`COL_W-1:0] col;
	logic [`COL_W-1:0] row;
	fill_state_t fill_state; // Observed by the bound checks
	logic win_ready;

	window_buffer u_buf (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix_data(pix_data),
		.window(window)
	);

	pos_counter u_cnt (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.pix_valid(pix_valid),
		.col(col),
		.row(row)
	);

	fill_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.pix_valid(pix_valid),
		.col(col),
		.row(row),
		.state(fill_state),
		.win_ready(win_ready)
	);

	rank_select u_rank (
		.clk(clk),
		.rst(rst),
		.window(window),
		.win_ready(win_ready),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

//--- rank_select.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module rank_select (
	input logic clk,
	input logic rst,
	input win_filter_pkg::win_u window,
	input logic win_ready,
	output logic out_valid,
	output win_filter_pkg::filt_out_t out_data
);
	import win_filter_pkg::*;

	localparam int MID = (`WIN_N - 1) / 2;

	logic [`POS_W-1:0] rank [`WIN_N];
	onehot_t med_hot;
	pos_t med_pos;

	// Ties are broken by cell index so every rank is distinct
	always_comb begin
		pixel_t ci;
		pixel_t cj;
		for (int i = 0; i < `WIN_N; i++) begin
			ci = window.flat[i*`PIX_W +: `PIX_W];
			rank[i] = '0;
			for (int j = 0; j < `WIN_N; j++) begin
				cj = window.flat[j*`PIX_W +: `PIX_W];
				if ((cj < ci) || ((cj == ci) && (j < i))) begin
					rank[i] = rank[i] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `WIN_N; i++) begin
			med_hot[i] = (rank[i] == MID[`POS_W-1:0]);
		end
	end

	position_encoder u_enc (
		.index(med_hot),
		.value(med_pos)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= win_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (win_ready) begin
			out_data.median <= window.cells[med_pos];
			out_data.pos <= med_pos;
		end
	end

endmodule

`default_nettype wire

//--- fill_fsm.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module fill_fsm (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic pix_valid,
	input logic [`COL_W-1:0] col,
	input logic [`COL_W-1:0] row,
	output win_filter_pkg::fill_state_t state,
	output logic win_ready
);
	import win_filter_pkg::*;

	localparam int EDGE = `WIN_W - 1;

	fill_state_t state_d;
	logic complete;

	// Pixel closes a window lying fully inside the image
	assign complete = pix_valid && (row >= EDGE[`COL_W-1:0]) && (col >= EDGE[`COL_W-1:0]);

	always_comb begin
		state_d = state;
		if (frame_start) begin
			state_d = FILL;
		end else begin
			case (state)
				FILL: if (complete) state_d = RUN;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			win_ready <= 1'b0;
		end else begin
			state <= state_d;
			win_ready <= complete && !frame_start && (state != IDLE);
		end
	end

endmodule

`default_nettype wire

//--- pos_counter.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module pos_counter (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic pix_valid,
	output logic [`COL_W-1:0] col,
	output logic [`COL_W-1:0] row
);
	localparam int LAST_COL = `IMG_W - 1;

	logic active; // A frame has been started

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (frame_start) begin
			active <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (pix_valid && active) begin
			if (col == LAST_COL[`COL_W-1:0]) begin
				col <= '0;
				if (row != '1) begin
					row <= row + 1'b1; // Holds at max
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- window_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module window_buffer (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input win_filter_pkg::pixel_t pix_data,
	output win_filter_pkg::win_u window
);
	import win_filter_pkg::*;

	// One line buffer per row above the newest
	pixel_t line_buf [`WIN_W-1][`IMG_W];
	pixel_t col_in [`WIN_W]; // Column entering the window, 0 on top
	win_u win_q;

	assign window = win_q;

	// Bottom gets the new pixel, each line tap feeds the row above
	always_comb begin
		col_in[`WIN_W-1] = pix_data;
		for (int k = 1; k < `WIN_W; k++) begin
			col_in[`WIN_W-1-k] = line_buf[k-1][`IMG_W-1];
		end
	end

	always_ff @(posedge clk) begin
		if (pix_valid) begin
			for (int k = 0; k < `WIN_W-1; k++) begin
				line_buf[k][0] <= col_in[`WIN_W-1-k];
				for (int i = 1; i < `IMG_W; i++) begin
					line_buf[k][i] <= line_buf[k][i-1];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			win_q <= '0;
		end else if (pix_valid) begin
			for (int r = 0; r < `WIN_W; r++) begin
				for (int c = 0; c < `WIN_W-1; c++) begin
					win_q.cells[r*`WIN_W+c] <= win_q.cells[r*`WIN_W+c+1]; // Shift left
				end
				win_q.cells[r*`WIN_W+`WIN_W-1] <= col_in[r];
			end
		end
	end

endmodule

`default_nettype wire

//--- position_encoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "win_filter_params.svh"

module position_encoder (
	input win_filter_pkg::onehot_t index,
	output win_filter_pkg::pos_t value
);
	import win_filter_pkg::*;

	generate
		case (`WIN_W)
			2: begin : g_w2
				always_comb begin
					case (index)
						onehot_t'(1): value = pos_t'(0);
						onehot_t'(2): value = pos_t'(1);
						onehot_t'(4): value = pos_t'(2);
						onehot_t'(8): value = pos_t'(3);
						default: value = pos_t'(0);
					endcase
				end
			end
			3: begin : g_w3
				always_comb begin
					case (index)
						onehot_t'(1): value = pos_t'(0);
						onehot_t'(2): value = pos_t'(1);
						onehot_t'(4): value = pos_t'(2);
						onehot_t'(8): value = pos_t'(3);
						onehot_t'(16): value = pos_t'(4);
						onehot_t'(32): value = pos_t'(5);
						onehot_t'(64): value = pos_t'(6);
						onehot_t'(128): value = pos_t'(7);
						onehot_t'(256): value = pos_t'(8);
						default: value = pos_t'(0); // None or several set
					endcase
				end
			end
			4: begin : g_w4
				always_comb begin
					case (index)
						onehot_t'(1): value = pos_t'(0);
						onehot_t'(2): value = pos_t'(1);
						onehot_t'(4): value = pos_t'(2);
						onehot_t'(8): value = pos_t'(3);
						onehot_t'(16): value = pos_t'(4);
						onehot_t'(32): value = pos_t'(5);
						onehot_t'(64): value = pos_t'(6);
						onehot_t'(128): value = pos_t'(7);
						onehot_t'(256): value = pos_t'(8);
						onehot_t'(512): value = pos_t'(9);
						onehot_t'(1024): value = pos_t'(10);
						onehot_t'(2048): value = pos_t'(11);
						onehot_t'(4096): value = pos_t'(12);
						onehot_t'(8192): value = pos_t'(13);
						onehot_t'(16384): value = pos_t'(14);
						onehot_t'(32768): value = pos_t'(15);
						default: value = pos_t'(0);
					endcase
				end
			end
			5: begin : g_w5
				always_comb begin
					case (index)
						onehot_t'(1): value = pos_t'(0);
						onehot_t'(2): value = pos_t'(1);
						onehot_t'(4): value = pos_t'(2);
						onehot_t'(8): value = pos_t'(3);
						onehot_t'(16): value = pos_t'(4);
						onehot_t'(32): value = pos_t'(5);
						onehot_t'(64): value = pos_t'(6);
						onehot_t'(128): value = pos_t'(7);
						onehot_t'(256): value = pos_t'(8);
						onehot_t'(512): value = pos_t'(9);
						onehot_t'(1024): value = pos_t'(10);
						onehot_t'(2048): value = pos_t'(11);
						onehot_t'(4096): value = pos_t'(12);
						onehot_t'(8192): value = pos_t'(13);
						onehot_t'(16384): value = pos_t'(14);
						onehot_t'(32768): value = pos_t'(15);
						onehot_t'(65536): value = pos_t'(16);
						onehot_t'(131072): value = pos_t'(17);
						onehot_t'(262144): value = pos_t'(18);
						onehot_t'(524288): value = pos_t'(19);
						onehot_t'(1048576): value = pos_t'(20);
						onehot_t'(2097152): value = pos_t'(21);
						onehot_t'(4194304): value = pos_t'(22);
						onehot_t'(8388608): value = pos_t'(23);
						onehot_t'(16777216): value = pos_t'(24);
						default: value = pos_t'(0);
					endcase
				end
			end
			default: begin : g_none
				assign value = '0; // Width not supported
			end
		endcase
	endgenerate

endmodule

`default_nettype wire

//--- win_filter_pkg.sv
`default_nettype none

`include "win_filter_params.svh"

package win_filter_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;

	typedef logic [`POS_W-1:0] pos_t;

	typedef logic [`WIN_N-1:0] onehot_t;

	// Cell 0 is the oldest pixel of the top row
	typedef union packed {
		logic [`WIN_N*`PIX_W-1:0] flat;
		pixel_t [`WIN_N-1:0] cells;
	} win_u;

	typedef enum logic [1:0] {
		IDLE,
		FILL,
		RUN
	} fill_state_t;

	typedef struct packed {
		pixel_t median;
		pos_t pos;
	} filt_out_t;

endpackage

`default_nettype wire

//--- win_filter_params.svh
`ifndef WIN_FILTER_PARAMS_SVH
`define WIN_FILTER_PARAMS_SVH

// Bits per grayscale pixel
`define PIX_W 8

// Window edge length; the encoder decodes widths 2 to 5
`define WIN_W 3

// Cells in one window
`define WIN_N (`WIN_W * `WIN_W)

// Pixels per image line
`define IMG_W 8

// Bits of a window position
`define POS_W 4

// Bits of the column and row counters
`define COL_W 4

`endif
